// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = batchFilterTb
FILELIST = batchFilter.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: batchFilter.f
+incdir+include
hdl/fixedPkg.sv
hdl/filterPkg.sv
hdl/sampleBanks.sv
hdl/coeffLut.sv
hdl/recursionUnit.sv
hdl/filterChannel.sv
hdl/batchFilter.sv
tb/batchFilterTb.sv

// File: hdl/batchFilter.sv
`default_nettype none
`include "batchFilter_params.svh"

module batchFilter
    import filterPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic [`N_CHANNELS-1:0] sampleIn,
    output logic signed [`OUT_W-1:0]    sampleOut,
    output logic                        outValid
);

    // Edges from the first input to the first valid output
    localparam int FILL_CYCLES = 4 * `BATCH_DEPTH + 2;
    localparam int FILL_W      = $clog2(FILL_CYCLES + 1);

    sampleSetT samples;
    logic batchStart;
    posT pos;

    logic signed [`OUT_W-1:0] partSum [`N_CHANNELS];
    logic signed [`OUT_W-1:0] chanSum;

    phaseT phase;
    logic [FILL_W-1:0] fillCnt;

    sampleBanks bankInst (
        .clk(clk), .rstN(rstN), .sampleIn(sampleIn),
        .samples(samples), .batchStart(batchStart), .pos(pos));

    for (genvar ch = 0; ch < `N_CHANNELS; ch++) begin : gChan
        filterChannel #(.CH(ch)) chanInst (
            .clk(clk), .rstN(rstN), .samples(samples),
            .batchStart(batchStart), .pos(pos), .partSum(partSum[ch]));
    end

    always_comb begin
        chanSum = '0;
        for (int i = 0; i < `N_CHANNELS; i++) begin
            chanSum = chanSum + partSum[i];
        end
    end

    always_ff @(posedge clk) begin
        sampleOut <= chanSum;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase   <= FILLING;
            fillCnt <= '0;
        end else if (phase == FILLING) begin
            if (fillCnt == FILL_W'(FILL_CYCLES)) begin
                phase <= STREAMING;
            end
            fillCnt <= fillCnt + FILL_W'(1);
        end
    end

    assign outValid = (phase == STREAMING);

endmodule

`default_nettype wire

// File: hdl/coeffLut.sv
`default_nettype none
`include "batchFilter_params.svh"

module coeffLut
    import fixedPkg::*;
    import filterPkg::*;
#(
    parameter int  CH  = 0,
    parameter dirT DIR = DIR_FWD
) (
    input  wire logic [`N_CHANNELS-1:0] word,
    output cplxT                        result
);

    cplxT row [`N_CHANNELS];

    always_comb begin
        for (int j = 0; j < `N_CHANNELS; j++) begin
            if (DIR == DIR_FWD) begin
                row[j] = feedF[CH][j];
            end else begin
                row[j] = feedB[CH][j];
            end
        end
    end

    // Set bit adds the coefficient, clear bit subtracts it
    always_comb begin
        cplxT acc;
        acc = CPLX_ZERO;
        for (int j = 0; j < `N_CHANNELS; j++) begin
            if (word[j]) begin
                acc = cAdd(acc, row[j]);
            end else begin
                acc = cSub(acc, row[j]);
            end
        end
        result = acc;
    end

endmodule

`default_nettype wire

// File: hdl/filterChannel.sv
`default_nettype none
`include "batchFilter_params.svh"

module filterChannel
    import fixedPkg::*;
    import filterPkg::*;
#(
    parameter int CH = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire sampleSetT            samples,
    input  wire logic                 batchStart,
    input  wire posT                  pos,
    output logic signed [`OUT_W-1:0]  partSum
);

    localparam int D = `BATCH_DEPTH;

    cplxT lookDrive;
    cplxT fwdDrive;
    cplxT bwdDrive;
    cplxT lookState;
    cplxT fwdState;
    cplxT bwdState;
    cplxT lookEnd;
    cplxT fwdWeighted;
    cplxT bwdWeighted;

    logic [2:0] warmCnt;
    logic fwdLoad;

    fixT fwdMem [2][D];
    fixT bwdMem [2][D];
    fixT fwdStored;
    fixT bwdStored;
    posT posD;
    logic pingSel;

    coeffLut #(.CH(CH), .DIR(DIR_BWD)) lookLut (.word(samples.look), .result(lookDrive));
    coeffLut #(.CH(CH), .DIR(DIR_FWD)) fwdLut (.word(samples.fwd), .result(fwdDrive));
    coeffLut #(.CH(CH), .DIR(DIR_BWD)) bwdLut (.word(samples.bwd), .result(bwdDrive));

    // Lookahead restarts from zero every batch
    recursionUnit #(.CH(CH), .DIR(DIR_BWD)) lookRec (
        .clk(clk), .rstN(rstN), .load(batchStart), .loadVal(CPLX_ZERO),
        .drive(lookDrive), .state(lookState));

    recursionUnit #(.CH(CH), .DIR(DIR_FWD)) fwdRec (
        .clk(clk), .rstN(rstN), .load(fwdLoad), .loadVal(CPLX_ZERO),
        .drive(fwdDrive), .state(fwdState));

    // Backward pass seeded with where the lookahead ended
    recursionUnit #(.CH(CH), .DIR(DIR_BWD)) bwdRec (
        .clk(clk), .rstN(rstN), .load(batchStart), .loadVal(lookState),
        .drive(bwdDrive), .state(bwdState));

    // Forward state starts clean once batch 0 reaches the forward pass
    assign fwdLoad = batchStart && (warmCnt == 3'd3);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            warmCnt <= '0;
        end else if (batchStart && warmCnt != 3'd4) begin
            warmCnt <= warmCnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (batchStart) begin
            lookEnd <= lookState;
        end
    end

    assign fwdWeighted = cMul(weightF[CH], fwdState);
    assign bwdWeighted = cMul(weightB[CH], bwdState);

    // Recursion outputs lag the samples by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            posD    <= '0;
            pingSel <= 1'b0;
        end else begin
            posD    <= pos;
            pingSel <= pingSel ^ batchStart;
        end
    end

    always_ff @(posedge clk) begin
        fwdMem[pingSel][posD]                <= fwdWeighted.re;
        bwdMem[pingSel][posT'(D - 1) - posD] <= bwdWeighted.re;
    end

    // Other bank holds the complete previous batch
    assign fwdStored = fwdMem[~pingSel][posD];
    assign bwdStored = bwdMem[~pingSel][posD];
    assign partSum   = `OUT_W'(fwdStored) + `OUT_W'(bwdStored);

    // Checked once the lookahead has seen real data
    assert property (@(posedge clk) disable iff (!rstN)
        batchStart && warmCnt >= 3'd3 |=>
            bwdState == cAdd(cMul(lambdaB[CH], lookEnd), $past(bwdDrive)));

endmodule

`default_nettype wire

// File: hdl/filterPkg.sv
`default_nettype none
`include "batchFilter_params.svh"

package filterPkg;
    import fixedPkg::*;

    // Bank written during the current batch period
    typedef enum logic [1:0] {BANK0, BANK1, BANK2, BANK3} bankSelT;

    typedef enum logic {FILLING, STREAMING} phaseT;

    // Coefficient set of a lookup or recursion
    typedef enum logic {DIR_FWD, DIR_BWD} dirT;

    typedef logic [$clog2(`BATCH_DEPTH)-1:0] posT;

    typedef struct packed {
        logic [`N_CHANNELS-1:0] look;
        logic [`N_CHANNELS-1:0] fwd;
        logic [`N_CHANNELS-1:0] bwd;
    } sampleSetT;

    // Q3.14 values, one row per channel
    localparam cplxT lambdaF [`N_CHANNELS] = '{
        cplx(14746, 1638), cplx(13926, -4096), cplx(13107, 5734)};
    localparam cplxT lambdaB [`N_CHANNELS] = '{
        cplx(14746, -1638), cplx(13926, 4096), cplx(13107, -5734)};

    // Indexed by channel, then input bit
    localparam cplxT feedF [`N_CHANNELS][`N_CHANNELS] = '{
        '{cplx(1638, 410), cplx(819, -205), cplx(410, 102)},
        '{cplx(1229, -614), cplx(614, 307), cplx(307, -154)},
        '{cplx(1024, 819), cplx(512, -410), cplx(256, 205)}};
    localparam cplxT feedB [`N_CHANNELS][`N_CHANNELS] = '{
        '{cplx(1638, -410), cplx(819, 205), cplx(410, -102)},
        '{cplx(1229, 614), cplx(614, -307), cplx(307, 154)},
        '{cplx(1024, -819), cplx(512, 410), cplx(256, -205)}};

    localparam cplxT weightF [`N_CHANNELS] = '{
        cplx(4096, 1024), cplx(3277, -819), cplx(2458, 1638)};
    localparam cplxT weightB [`N_CHANNELS] = '{
        cplx(4096, -1024), cplx(3277, 819), cplx(2458, -1638)};

endpackage

`default_nettype wire

// File: hdl/fixedPkg.sv
`default_nettype none
`include "batchFilter_params.svh"

package fixedPkg;

    typedef logic signed [`DATA_W-1:0] fixT;

    typedef struct packed {
        fixT re;
        fixT im;
    } cplxT;

    localparam cplxT CPLX_ZERO = '0;

    function automatic cplxT cplx(int r, int i);
        cplxT c;
        c.re = fixT'(r);
        c.im = fixT'(i);
        return c;
    endfunction

    // Drop the fraction bits of a full product and keep DATA_W bits
    function automatic fixT fixTrunc(logic signed [2*`DATA_W-1:0] prod);
        return fixT'(prod >>> `FRAC_W);
    endfunction

    function automatic fixT fixMul(fixT a, fixT b);
        logic signed [2*`DATA_W-1:0] prod;
        prod = a * b;
        return fixTrunc(prod);
    endfunction

    function automatic fixT fixAdd(fixT a, fixT b);
        return a + b;
    endfunction

    function automatic fixT fixSub(fixT a, fixT b);
        return a - b;
    endfunction

    function automatic cplxT cAdd(cplxT a, cplxT b);
        cplxT c;
        c.re = fixAdd(a.re, b.re);
        c.im = fixAdd(a.im, b.im);
        return c;
    endfunction

    function automatic cplxT cSub(cplxT a, cplxT b);
        cplxT c;
        c.re = fixSub(a.re, b.re);
        c.im = fixSub(a.im, b.im);
        return c;
    endfunction

    // Each partial product truncated before the sum
    function automatic cplxT cMul(cplxT a, cplxT b);
        cplxT c;
        c.re = fixSub(fixMul(a.re, b.re), fixMul(a.im, b.im));
        c.im = fixAdd(fixMul(a.re, b.im), fixMul(a.im, b.re));
        return c;
    endfunction

endpackage

`default_nettype wire

// File: hdl/recursionUnit.sv
`default_nettype none
`include "batchFilter_params.svh"

module recursionUnit
    import fixedPkg::*;
    import filterPkg::*;
#(
    parameter int  CH  = 0,
    parameter dirT DIR = DIR_FWD
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic load,
    input  wire cplxT loadVal,
    input  wire cplxT drive,
    output cplxT      state
);

    cplxT lambda;
    cplxT base;
    cplxT nextState;

    assign lambda = (DIR == DIR_FWD) ? lambdaF[CH] : lambdaB[CH];

    // A load replaces the previous state as the start of this step
    assign base = load ? loadVal : state;

    assign nextState = cAdd(cMul(lambda, base), drive);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= CPLX_ZERO;
        end else begin
            state <= nextState;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sampleBanks.sv
`default_nettype none
`include "batchFilter_params.svh"

module sampleBanks
    import filterPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic [`N_CHANNELS-1:0] sampleIn,
    output sampleSetT                   samples,
    output logic                        batchStart,
    output posT                         pos
);

    localparam int D = `BATCH_DEPTH;

    logic [`N_CHANNELS-1:0] mem [4][D];

    posT k;
    posT kRev;
    bankSelT cur;
    bankSelT prev;
    bankSelT oldest;
    logic [3:0] wrEn;

    assign kRev = posT'(D - 1) - k;

    // Batch p-1 feeds the lookahead, batch p-3 the forward and backward passes
    assign prev   = bankSelT'(cur - 2'd1);
    assign oldest = bankSelT'(cur + 2'd1);

    always_comb begin
        case (cur)
            BANK0:   wrEn = 4'b0001;
            BANK1:   wrEn = 4'b0010;
            BANK2:   wrEn = 4'b0100;
            default: wrEn = 4'b1000;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            k   <= '0;
            cur <= BANK0;
        end else begin
            if (k == posT'(D - 1)) begin
                k   <= '0;
                cur <= bankSelT'(cur + 2'd1);
            end else begin
                k <= k + posT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wrEn[b]) begin
                mem[b][k] <= sampleIn;
            end
        end
    end

    // Registered reads
    always_ff @(posedge clk) begin
        samples.look <= mem[prev][kRev];
        samples.fwd  <= mem[oldest][k];
        samples.bwd  <= mem[oldest][kRev];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            batchStart <= 1'b0;
            pos        <= '0;
        end else begin
            batchStart <= (k == '0);
            pos        <= k;
        end
    end

    // One bank written, and never one of the two being read
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot(wrEn) && !wrEn[prev] && !wrEn[oldest]);

endmodule

`default_nettype wire

// File: include/batchFilter_params.svh
`ifndef BATCH_FILTER_PARAMS_SVH
`define BATCH_FILTER_PARAMS_SVH

// Samples per batch
`define BATCH_DEPTH 16

// Recursion channels, also the modulator word width
`define N_CHANNELS 3

// Fixed-point format
`define FRAC_W 14
`define DATA_W 18

// Output sample width
`define OUT_W 20

`endif

// File: tb/batchFilterTb.sv
`default_nettype none
`include "batchFilter_params.svh"

module batchFilterTb
    import fixedPkg::*;
    import filterPkg::*;
();

    localparam int D = `BATCH_DEPTH;
    // Four batch periods plus the read and output registers
    localparam int FILL_LAT = 4 * D + 2;
    // Each run drives one batch more than it checks
    localparam int RUN_BATCHES = (4 + 1) + (8 + 1) + (6 + 1) + (20 + 1) + (6 + 1) + (4 + 1);
    // Reset and pipeline drain cost under four batch periods per run
    localparam int WATCHDOG_TIME = (RUN_BATCHES + 6 * 4 + 6) * D * 10;

    typedef logic [`N_CHANNELS-1:0] wordT;
    typedef enum {PAT_ZERO, PAT_ONES, PAT_ALT, PAT_RAND} patternT;
    typedef struct packed {
        longint re;
        longint im;
    } refCplxT;

    logic clk;
    logic rstN;
    wordT sampleIn;
    logic signed [`OUT_W-1:0] sampleOut;
    logic outValid;

    wordT stim [$];
    longint expected [$];
    int checked = 0;
    int totalChecked = 0;
    int errors = 0;
    int sinceRst = 0;
    int testCount = 0;
    int cyc;

    batchFilter batchFilter_inst (
        .clk(clk), .rstN(rstN), .sampleIn(sampleIn),
        .sampleOut(sampleOut), .outValid(outValid));

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Keep the low w bits as a signed value
    function automatic longint wrapTo(longint v, int w);
        longint m;
        m = longint'(1) << w;
        v = v & (m - 1);
        if (v >= m / 2) begin
            v = v - m;
        end
        return v;
    endfunction

    function automatic longint prodTrunc(longint a, longint b);
        return wrapTo((a * b) >>> `FRAC_W, `DATA_W);
    endfunction

    function automatic refCplxT toRef(cplxT c);
        refCplxT r;
        r.re = longint'(c.re);
        r.im = longint'(c.im);
        return r;
    endfunction

    function automatic refCplxT mulRef(refCplxT a, refCplxT b);
        refCplxT r;
        r.re = wrapTo(prodTrunc(a.re, b.re) - prodTrunc(a.im, b.im), `DATA_W);
        r.im = wrapTo(prodTrunc(a.re, b.im) + prodTrunc(a.im, b.re), `DATA_W);
        return r;
    endfunction

    function automatic refCplxT stepRef(refCplxT lam, refCplxT s, refCplxT d);
        refCplxT r;
        r = mulRef(lam, s);
        r.re = wrapTo(r.re + d.re, `DATA_W);
        r.im = wrapTo(r.im + d.im, `DATA_W);
        return r;
    endfunction

    // Plus the feed coefficient for a set bit, minus it for a clear bit
    function automatic refCplxT lookupRef(int ch, bit bwd, wordT w);
        refCplxT r;
        refCplxT c;
        r = '0;
        for (int j = 0; j < `N_CHANNELS; j++) begin
            c = toRef(bwd ? feedB[ch][j] : feedF[ch][j]);
            if (w[j]) begin
                r.re += c.re;
                r.im += c.im;
            end else begin
                r.re -= c.re;
                r.im -= c.im;
            end
        end
        r.re = wrapTo(r.re, `DATA_W);
        r.im = wrapTo(r.im, `DATA_W);
        return r;
    endfunction

    function automatic void computeExpected(int nCheck);
        refCplxT fs;
        refCplxT ls;
        refCplxT bs;
        refCplxT t;
        int nOut;
        nOut = nCheck * D;
        expected.delete();
        for (int n = 0; n < nOut; n++) begin
            expected.push_back(0);
        end
        for (int ch = 0; ch < `N_CHANNELS; ch++) begin
            fs = '0;
            for (int n = 0; n < nOut; n++) begin
                fs = stepRef(toRef(lambdaF[ch]), fs, lookupRef(ch, 1'b0, stim[n]));
                t = mulRef(toRef(weightF[ch]), fs);
                expected[n] += t.re;
            end
            for (int b = 0; b < nCheck; b++) begin
                // Lookahead runs over the next batch reversed, from zero
                ls = '0;
                for (int j = D - 1; j >= 0; j--) begin
                    ls = stepRef(toRef(lambdaB[ch]), ls,
                        lookupRef(ch, 1'b1, stim[(b + 1) * D + j]));
                end
                bs = ls;
                for (int j = D - 1; j >= 0; j--) begin
                    bs = stepRef(toRef(lambdaB[ch]), bs, lookupRef(ch, 1'b1, stim[b * D + j]));
                    t = mulRef(toRef(weightB[ch]), bs);
                    expected[b * D + j] += t.re;
                end
            end
        end
        foreach (expected[n]) begin
            expected[n] = wrapTo(expected[n], `OUT_W);
        end
    endfunction

    function automatic void makeStim(patternT pat, int nBatches);
        stim.delete();
        for (int n = 0; n < nBatches * D; n++) begin
            case (pat)
                PAT_ZERO: stim.push_back('0);
                PAT_ONES: stim.push_back('1);
                PAT_ALT:  stim.push_back((n % 2 == 0) ? wordT'(32'h5555_5555)
                                                      : wordT'(32'haaaa_aaaa));
                default:  stim.push_back(wordT'($urandom()));
            endcase
        end
    endfunction

    // Reset, then stream the first nDrive samples of a fresh stimulus
    task automatic driveRun(patternT pat, int nCheck, int nDrive);
        makeStim(pat, nCheck + 1);
        @(posedge clk);
        rstN <= 1'b0;
        sampleIn <= '0;
        computeExpected(nCheck);
        checked = 0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        for (int n = 0; n < nDrive; n++) begin
            sampleIn <= stim[n];
            @(posedge clk);
        end
    endtask

    // Whole stimulus, then wait for every expected sample
    task automatic runOnce(patternT pat, int nCheck);
        driveRun(pat, nCheck, (nCheck + 1) * D);
        wait (checked == expected.size());
    endtask

    task automatic report(string name, int errBefore);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errors - errBefore);
    endtask

    // Outputs sampled mid-cycle, counted in cycles since reset release
    always @(negedge clk) begin
        if (rstN !== 1'b1) begin
            sinceRst = 0;
            if (outValid) begin
                errors++;
                $display("FAILED at %0t: outValid high during reset", $time);
            end
        end else begin
            cyc = sinceRst - 1;
            sinceRst++;
            if (outValid !== (cyc >= FILL_LAT)) begin
                errors++;
                $display("FAILED at %0t: outValid is %b at cycle %0d after reset",
                    $time, outValid, cyc);
            end else if (outValid && cyc - FILL_LAT < expected.size()) begin
                if (longint'(sampleOut) != expected[cyc - FILL_LAT]) begin
                    errors++;
                    $display("FAILED at %0t: sample %0d is %0d, expected %0d",
                        $time, cyc - FILL_LAT, sampleOut, expected[cyc - FILL_LAT]);
                end
                checked++;
                totalChecked++;
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int errBefore;
        rstN <= 1'b0;
        sampleIn <= '0;
        void'($urandom(32'h51f621f6));

        errBefore = errors;
        runOnce(PAT_ZERO, 4);
        report("outValid timing after reset", errBefore);

        errBefore = errors;
        runOnce(PAT_ONES, 8);
        report("all-ones input", errBefore);

        errBefore = errors;
        runOnce(PAT_ALT, 6);
        report("alternating input", errBefore);

        errBefore = errors;
        runOnce(PAT_RAND, 20);
        report("random input", errBefore);

        // Reset lands while the first run is still taking input
        errBefore = errors;
        driveRun(PAT_RAND, 6, 5 * D + D / 2);
        runOnce(PAT_RAND, 4);
        report("reset in the middle of a run", errBefore);

        $display("%0d tests, %0d samples checked, %0d errors", testCount, totalChecked, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
